// File: list.f
+incdir+hdl
hdl/exu_pkg.sv
hdl/operand_select.sv
hdl/op_queue.sv
hdl/iter_mul.sv
hdl/alu_exec.sv
hdl/exu_top.sv
sim/exu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := exu_tb
FLIST      := list.f
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All tests passed!
SOURCES    := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/exu_trace.txt
# name op sel_a sel_b word pc rs1 rs2 csr imm flush expected
# op, selects, word and flush in decimal, operands and expected result in hex
sel_pc_pass_a 2 0 0 0 80001000 1234 5 7 9 0 80001000
sel_rs1_word 2 1 0 1 0 ffffffff87654321 0 0 0 0 87654321
sel_rs2_pass_b 3 1 1 0 0 0 aaaa 300 9 0 aaaa
sel_csr_pass_b 3 1 2 0 0 0 aaaa 300 9 0 300
sel_imm_pass_b 3 1 0 0 0 0 aaaa 300 fffffffffffffff0 0 fffffffffffffff0
add_pc_imm 0 0 0 0 1000 55 0 0 4 0 1004
add_rs1w_rs2 0 1 1 1 0 deadbeef00000010 20 0 0 0 30
sub_neg 1 1 1 0 0 10 20 0 0 0 fffffffffffffff0
xor_rs2 4 1 1 0 0 ff00ff00 0ff00ff0 0 0 0 f0f0f0f0
or_csr 5 1 2 0 0 f000 0 f 0 0 f00f
and_rs2 6 1 1 0 0 ff00ff00 0ff00ff0 0 0 0 0f000f00
sll_max 7 1 0 0 0 1 0 0 3f 0 8000000000000000
srl_rs2 8 1 1 0 0 8000000000000000 4 0 0 0 0800000000000000
sra_dword 9 1 1 0 0 8000000000000000 4 0 0 0 f800000000000000
sra_word 9 1 1 1 0 ffffffff80000000 24 0 0 0 f8000000
slt_signed 10 1 1 0 0 ffffffffffffffff 1 0 0 0 1
sltu_unsigned 11 1 1 0 0 ffffffffffffffff 1 0 0 0 0
eq_equal 12 1 1 0 0 55 55 0 0 0 1
ge_signed 13 1 1 0 0 1 ffffffffffffffff 0 0 0 1
geu_unsigned 14 1 1 0 0 1 ffffffffffffffff 0 0 0 0
div_neg 16 1 1 0 0 ffffffffffffff9c 7 0 0 0 fffffffffffffff2
rem_neg 18 1 1 0 0 ffffffffffffff9c 7 0 0 0 fffffffffffffffe
divu_pos 17 1 1 0 0 64 7 0 0 0 e
remu_pos 19 1 1 0 0 64 7 0 0 0 2
div_zero 16 1 1 0 0 1234 0 0 0 0 ffffffffffffffff
divu_zero 17 1 1 0 0 1234 0 0 0 0 ffffffffffffffff
rem_zero 18 1 1 0 0 1234 0 0 0 0 1234
remu_zero 19 1 1 0 0 1234 0 0 0 0 1234
mul_wrap 15 1 1 0 0 ffffffffffffffff 3 0 0 0 fffffffffffffffd
q_add 0 1 1 0 0 1 2 0 0 0 3
q_xor 4 1 1 0 0 f 3 0 0 0 c
q_sub 1 1 1 0 0 5 8 0 0 0 fffffffffffffffd
mul_shift 15 1 1 0 0 123456789 1000 0 0 0 123456789000
burst_add 0 1 0 0 0 a 0 0 1 0 b
burst_sll 7 1 0 0 0 3 0 0 4 0 30
burst_sltu 11 1 1 0 0 1 2 0 0 0 1
burst_and 6 1 1 0 0 f0 3c 0 0 0 30
mul_pc_imm 15 0 0 0 10 0 0 0 10 0 100
fl_mul 15 1 1 0 0 5 6 0 0 1 1e
fl_add 0 1 1 0 0 1 1 0 0 1 2
post_add 0 1 1 0 0 7 8 0 0 0 f
post_mul 15 1 1 0 0 7 9 0 0 0 3f
post_eq 12 1 1 0 0 3 4 0 0 0 0

// File: sim/exu_tb.sv
`timescale 1ns/100ps
`include "exu_cfg.svh"

module exu_tb;
    import exu_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic                 issue;
    logic                 issue_d;
    alu_op_e              op;
    sel_a_e               sel_a;
    sel_b_e               sel_b;
    logic                 word;
    logic [`EXU_XLEN-1:0] pc;
    logic [`EXU_XLEN-1:0] rs1;
    logic [`EXU_XLEN-1:0] rs2;
    logic [`EXU_XLEN-1:0] csr;
    logic [`EXU_XLEN-1:0] imm;
    logic                 flush;
    logic                 full;
    logic                 res_valid;
    logic [`EXU_XLEN-1:0] res;

    // trace columns, one entry per line
    string                t_name  [$];
    logic [4:0]           t_op    [$];
    logic                 t_sa    [$];
    logic [1:0]           t_sb    [$];
    logic                 t_word  [$];
    logic [`EXU_XLEN-1:0] t_pc    [$];
    logic [`EXU_XLEN-1:0] t_rs1   [$];
    logic [`EXU_XLEN-1:0] t_rs2   [$];
    logic [`EXU_XLEN-1:0] t_csr   [$];
    logic [`EXU_XLEN-1:0] t_imm   [$];
    logic                 t_flush [$];
    logic [`EXU_XLEN-1:0] t_exp   [$];

    // scoreboard in issue order
    logic [`EXU_XLEN-1:0] exp_q   [$];
    string                name_q  [$];
    string                killed_q [$];
    string                cur_name;
    logic [`EXU_XLEN-1:0] cur_exp;
    int                   n_lines = 0;
    int                   n_pass = 0;
    int                   n_fail = 0;
    int                   n_flushed = 0;

    exu_top i_exu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .op        (op),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .word      (word),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .flush     (flush),
        .full      (full),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // issue level of the cycle before the current one
    always @(posedge clk) begin
        issue_d <= issue;
    end

    task automatic read_trace();
        int                   fd;
        int                   n;
        string                line;
        string                f_name;
        logic [4:0]           f_op;
        logic                 f_sa;
        logic [1:0]           f_sb;
        logic                 f_word;
        logic                 f_flush;
        logic [`EXU_XLEN-1:0] f_pc;
        logic [`EXU_XLEN-1:0] f_rs1;
        logic [`EXU_XLEN-1:0] f_rs2;
        logic [`EXU_XLEN-1:0] f_csr;
        logic [`EXU_XLEN-1:0] f_imm;
        logic [`EXU_XLEN-1:0] f_exp;
        fd = $fopen("sim/exu_trace.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                // skip comments and blank lines
                if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %d %d %d %d %h %h %h %h %h %d %h", f_name, f_op,
                                f_sa, f_sb, f_word, f_pc, f_rs1, f_rs2, f_csr, f_imm,
                                f_flush, f_exp);
                    if (n == 12) begin
                        t_name.push_back(f_name);
                        t_op.push_back(f_op);
                        t_sa.push_back(f_sa);
                        t_sb.push_back(f_sb);
                        t_word.push_back(f_word);
                        t_pc.push_back(f_pc);
                        t_rs1.push_back(f_rs1);
                        t_rs2.push_back(f_rs2);
                        t_csr.push_back(f_csr);
                        t_imm.push_back(f_imm);
                        t_flush.push_back(f_flush);
                        t_exp.push_back(f_exp);
                    end else begin
                        $display("Malformed trace line: %s", line);
                        n_fail++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // full seen here can still rise on the next edge when a line went out two cycles back
    task automatic issue_line(input int i);
        @(negedge clk);
        while (full || issue_d) begin
            @(posedge clk);
            issue <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        issue <= 1'b1;
        op    <= alu_op_e'(t_op[i]);
        sel_a <= sel_a_e'(t_sa[i]);
        sel_b <= sel_b_e'(t_sb[i]);
        word  <= t_word[i];
        pc    <= t_pc[i];
        rs1   <= t_rs1[i];
        rs2   <= t_rs2[i];
        csr   <= t_csr[i];
        imm   <= t_imm[i];
        if (t_flush[i]) begin
            killed_q.push_back(t_name[i]);
        end else begin
            exp_q.push_back(t_exp[i]);
            name_q.push_back(t_name[i]);
        end
    endtask

    task automatic wait_drain();
        @(posedge clk);
        issue <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // wait a few cycles so the multiply is still running at the flush
    task automatic flush_pending();
        repeat (4) begin
            @(posedge clk);
            issue <= 1'b0;
        end
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        while (killed_q.size() != 0) begin
            $display("%s: flushed, no result expected", killed_q.pop_front());
            n_flushed++;
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("Unexpected result %h with no operation pending", res);
                n_fail++;
            end
            if (exp_q.size() != 0) begin
                cur_name = name_q.pop_front();
                cur_exp  = exp_q.pop_front();
                assert (res === cur_exp) begin
                    $display("%s: ok, result %h", cur_name, res);
                    n_pass++;
                end else begin
                    $display("Mismatch %s expected %h actual %h", cur_name, cur_exp, res);
                    n_fail++;
                end
            end
        end
        // every queued entry still awaits its result
        if (rst_n) begin
            assert (!full || exp_q.size() + killed_q.size() >= `EXU_QDEPTH - 1) else begin
                $display("Full is high with only %0d operations outstanding",
                         exp_q.size() + killed_q.size());
                n_fail++;
            end
        end
    end

    initial begin
        int gap;
        rst_n = 1'b0;
        issue = 1'b0;
        op    = op_add;
        sel_a = a_pc;
        sel_b = b_imm;
        word  = 1'b0;
        pc    = '0;
        rs1   = '0;
        rs2   = '0;
        csr   = '0;
        imm   = '0;
        flush = 1'b0;
        void'($urandom(92900));
        read_trace();
        n_lines = t_name.size();
        assert (n_lines > 0) else begin
            $display("Trace file sim/exu_trace.txt is missing or holds no operations");
            n_fail++;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_lines; i++) begin
            gap = $urandom % 4;
            // a flushed group starts with nothing else in flight
            if (t_flush[i] && (i == 0 || !t_flush[i-1])) begin
                wait_drain();
            end
            repeat (gap) begin
                @(posedge clk);
                issue <= 1'b0;
            end
            issue_line(i);
            if (t_flush[i] && (i == n_lines - 1 || !t_flush[i+1])) begin
                flush_pending();
            end
        end
        wait_drain();
        // room for any stray result
        repeat (10) @(posedge clk);
        $display("%0d lines: %0d passed, %0d failed, %0d flushed",
                 n_lines, n_pass, n_fail, n_flushed);
        if (n_fail == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // cycle limit scales with the trace and allows a full multiply per line
    initial begin
        wait (n_lines > 0);
        repeat (16 + n_lines * (`EXU_MUL_STEPS + 10)) @(posedge clk);
        $display("Timeout: %0d results still pending at the cycle limit", exp_q.size());
        $display("Test failures found");
        $finish;
    end

endmodule

// File: hdl/exu_top.sv
`timescale 1ns/100ps
`include "exu_cfg.svh"

module exu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  exu_pkg::alu_op_e     op,
    input  exu_pkg::sel_a_e      sel_a,
    input  exu_pkg::sel_b_e      sel_b,
    input  logic                 word,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] rs1,
    input  logic [`EXU_XLEN-1:0] rs2,
    input  logic [`EXU_XLEN-1:0] csr,
    input  logic [`EXU_XLEN-1:0] imm,
    input  logic                 flush,
    output logic                 full,
    output logic                 res_valid,
    output logic [`EXU_XLEN-1:0] res
);
    import exu_pkg::*;

    logic       push;
    exu_entry_s entry;
    exu_entry_s head;
    logic       empty;
    logic       pop;

    // issue side, operands picked and registered
    operand_select i_operand_select (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .issue (issue),
        .op    (op),
        .sel_a (sel_a),
        .sel_b (sel_b),
        .word  (word),
        .pc    (pc),
        .rs1   (rs1),
        .rs2   (rs2),
        .csr   (csr),
        .imm   (imm),
        .push  (push),
        .entry (entry)
    );

    op_queue i_op_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .push  (push),
        .entry (entry),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (full)
    );

    // execute side, results leave in queue order
    alu_exec i_alu_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .head      (head),
        .empty     (empty),
        .pop       (pop),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

// File: hdl/alu_exec.sv
`timescale 1ns/100ps
`include "exu_cfg.svh"

module alu_exec (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  exu_pkg::exu_entry_s  head,
    input  logic                 empty,
    output logic                 pop,
    output logic                 res_valid,
    output logic [`EXU_XLEN-1:0] res
);
    import exu_pkg::*;

    localparam int xlen = `EXU_XLEN;
    localparam int half = `EXU_XLEN / 2;

    alu_word_u       a;
    alu_word_u       b;
    logic [5:0]      shamt;
    logic [half-1:0] sra_lo;
    logic            b_zero;
    logic            div_ovf;
    logic [xlen-1:0] den_s;
    logic [xlen-1:0] den_u;
    logic [xlen-1:0] quot_s;
    logic [xlen-1:0] rem_s;
    logic [xlen-1:0] quot_u;
    logic [xlen-1:0] rem_u;
    logic [xlen-1:0] alu_result;
    logic            is_mul;
    logic            busy;
    logic            mul_start;
    logic            mul_done;
    logic [xlen-1:0] mul_product;

    assign a      = head.a;
    assign b      = head.b;
    assign shamt  = b.dword[5:0];
    assign is_mul = (head.op == op_mul);

    // never take a new entry while a multiply is running or on flush
    assign pop       = ~busy & ~empty & ~flush;
    assign mul_start = pop & is_mul;

    // word sra works on the low half only
    assign sra_lo = $signed(a.half.lo) >>> b.dword[4:0];

    // divisor of 1 covers divide by zero and the signed overflow case,
    // where quotient = dividend and remainder = 0 come out naturally
    assign b_zero  = (b.dword == '0);
    assign div_ovf = (a.dword == {1'b1, {(xlen-1){1'b0}}}) && (b.dword == '1);
    assign den_s   = (b_zero | div_ovf) ? xlen'(1) : b.dword;
    assign den_u   = b_zero ? xlen'(1) : b.dword;
    assign quot_s  = $signed(a.dword) / $signed(den_s);
    assign rem_s   = $signed(a.dword) % $signed(den_s);
    assign quot_u  = a.dword / den_u;
    assign rem_u   = a.dword % den_u;

    always_comb begin
        case (head.op)
            op_add:    alu_result = a.dword + b.dword;
            op_sub:    alu_result = a.dword - b.dword;
            op_pass_a: alu_result = a.dword;
            op_pass_b: alu_result = b.dword;
            op_xor:    alu_result = a.dword ^ b.dword;
            op_or:     alu_result = a.dword | b.dword;
            op_and:    alu_result = a.dword & b.dword;
            op_sll:    alu_result = a.dword << shamt;
            op_srl:    alu_result = a.dword >> shamt;
            op_sra: begin
                if (head.word) begin
                    alu_result = {{half{1'b0}}, sra_lo};
                end else begin
                    alu_result = $signed(a.dword) >>> shamt;
                end
            end
            op_slt:    alu_result = xlen'($signed(a.dword) < $signed(b.dword));
            op_sltu:   alu_result = xlen'(a.dword < b.dword);
            op_eq:     alu_result = xlen'(a.dword == b.dword);
            op_ge:     alu_result = xlen'($signed(a.dword) >= $signed(b.dword));
            op_geu:    alu_result = xlen'(a.dword >= b.dword);
            // RISC-V results for a zero divisor
            op_div:    alu_result = b_zero ? '1 : quot_s;
            op_divu:   alu_result = b_zero ? '1 : quot_u;
            op_rem:    alu_result = b_zero ? a.dword : rem_s;
            op_remu:   alu_result = b_zero ? a.dword : rem_u;
            default:   alu_result = '0;
        endcase
    end

    iter_mul i_iter_mul (
        .clk     (clk),
        .rst_n   (rst_n),
        .abort   (flush),
        .start   (mul_start),
        .a       (a.dword),
        .b       (b.dword),
        .done    (mul_done),
        .product (mul_product)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            res_valid <= 1'b0;
            res       <= '0;
        end else if (flush) begin
            busy      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (busy) begin
                // stalled until the multiplier reports
                if (mul_done) begin
                    busy      <= 1'b0;
                    res_valid <= 1'b1;
                    res       <= mul_product;
                end
            end else if (pop) begin
                if (is_mul) begin
                    busy <= 1'b1;
                end else begin
                    res_valid <= 1'b1;
                    res       <= alu_result;
                end
            end
        end
    end

endmodule

// File: hdl/iter_mul.sv
`timescale 1ns/100ps
`include "exu_cfg.svh"

module iter_mul (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 abort,
    input  logic                 start,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    output logic                 done,
    output logic [`EXU_XLEN-1:0] product
);

    localparam int steps = `EXU_MUL_STEPS;
    localparam int cw    = $clog2(steps);

    logic                 running;
    logic [cw-1:0]        step_cnt;
    logic [`EXU_XLEN-1:0] mcand;
    logic [`EXU_XLEN-1:0] mplier;
    logic [`EXU_XLEN-1:0] acc;

    // accumulator holds the low half once done rises
    assign product = acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running  <= 1'b0;
            step_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (abort) begin
                running <= 1'b0;
            end else if (start) begin
                running  <= 1'b1;
                step_cnt <= '0;
            end else if (running) begin
                step_cnt <= step_cnt + 1'b1;
                // last step, the sum lands together with done
                if (step_cnt == cw'(steps - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // one multiplier bit per cycle, lsb first
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

// File: hdl/op_queue.sv
`timescale 1ns/100ps
`include "exu_cfg.svh"

module op_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                push,
    input  exu_pkg::exu_entry_s entry,
    input  logic                pop,
    output exu_pkg::exu_entry_s head,
    output logic                empty,
    output logic                full
);
    import exu_pkg::*;

    localparam int depth = `EXU_QDEPTH;
    localparam int aw    = $clog2(depth);
    localparam int cw    = aw + 1;

    exu_entry_s      mem [depth];
    logic [aw-1:0]   wr_ptr;
    logic [aw-1:0]   rd_ptr;
    logic [cw-1:0]   count;
    logic            full_q;
    logic            wr_en;
    logic            rd_en;

    // the push now arriving was issued while full_q was the full level
    assign wr_en = push & ~full_q;
    assign rd_en = pop & ~empty;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    // one slot kept free for the push already in the producer
    assign full  = (count >= cw'(depth - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full_q <= 1'b0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full_q <= 1'b0;
        end else begin
            full_q <= full;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= entry;
        end
    end

endmodule

// File: hdl/operand_select.sv
`timescale 1ns/100ps
`include "exu_cfg.svh"

module operand_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 issue,
    input  exu_pkg::alu_op_e     op,
    input  exu_pkg::sel_a_e      sel_a,
    input  exu_pkg::sel_b_e      sel_b,
    input  logic                 word,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] rs1,
    input  logic [`EXU_XLEN-1:0] rs2,
    input  logic [`EXU_XLEN-1:0] csr,
    input  logic [`EXU_XLEN-1:0] imm,
    output logic                 push,
    output exu_pkg::exu_entry_s  entry
);
    import exu_pkg::*;

    alu_word_u a_mux;
    alu_word_u b_mux;

    // first operand is pc or rs1
    always_comb begin
        a_mux.dword = pc;
        if (sel_a == a_rs1) begin
            a_mux.dword = rs1;
            // word mode keeps only the low word of rs1
            if (word) begin
                a_mux.half.hi = '0;
            end
        end
    end

    always_comb begin
        case (sel_b)
            b_rs2:   b_mux.dword = rs2;
            b_csr:   b_mux.dword = csr;
            default: b_mux.dword = imm;
        endcase
    end

    // one push per issue, an issue in the flush cycle is lost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= issue & ~flush;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            entry.op   <= op;
            entry.word <= word;
            entry.a    <= a_mux;
            entry.b    <= b_mux;
        end
    end

endmodule

// File: hdl/exu_pkg.sv
`include "exu_cfg.svh"

package exu_pkg;

    // execute unit operation codes
    typedef enum logic [4:0] {
        op_add    = 5'd0,
        op_sub    = 5'd1,
        op_pass_a = 5'd2,
        op_pass_b = 5'd3,
        op_xor    = 5'd4,
        op_or     = 5'd5,
        op_and    = 5'd6,
        op_sll    = 5'd7,
        op_srl    = 5'd8,
        op_sra    = 5'd9,
        op_slt    = 5'd10,
        op_sltu   = 5'd11,
        op_eq     = 5'd12,
        op_ge     = 5'd13,
        op_geu    = 5'd14,
        op_mul    = 5'd15,
        op_div    = 5'd16,
        op_divu   = 5'd17,
        op_rem    = 5'd18,
        op_remu   = 5'd19
    } alu_op_e;

    typedef enum logic {
        a_pc  = 1'b0,
        a_rs1 = 1'b1
    } sel_a_e;

    // code 3 is unused and falls back to imm
    typedef enum logic [1:0] {
        b_imm = 2'd0,
        b_rs2 = 2'd1,
        b_csr = 2'd2
    } sel_b_e;

    typedef struct packed {
        logic [`EXU_XLEN/2-1:0] hi;
        logic [`EXU_XLEN/2-1:0] lo;
    } alu_half_s;

    // one operand, seen whole or as two words
    typedef union packed {
        logic [`EXU_XLEN-1:0] dword;
        alu_half_s            half;
    } alu_word_u;

    typedef struct packed {
        alu_op_e   op;
        logic      word;
        alu_word_u a;
        alu_word_u b;
    } exu_entry_s;

endpackage

// File: hdl/exu_cfg.svh
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// datapath width in bits
`define EXU_XLEN 64

// operation queue entries, keep a power of two
`define EXU_QDEPTH 4

// shift-add iterations per multiply, one bit of the multiplier each
`define EXU_MUL_STEPS 64

`endif
